//--- filelist.f
+incdir+verilog
verilog/aes_ks_types_pkg.sv
verilog/aes_ks_math_pkg.sv
verilog/aes_key_expand.sv
verilog/aes_key_sched_ctrl.sv
verilog/aes_round_key_bank.sv
verilog/aes_key_sched_top.sv
dv/aes_key_sched_sva.sv
dv/aes_key_sched_tb.sv

//--- dv/aes_key_sched_tb.sv
/*
  AES key schedule testbench
  Expands FIPS-197 and random keys, then reads back every round key
  and compares it with a reference word schedule
*/
`timescale 1ns/100ps
`include "aes_ks_settings.svh"

module aes_key_sched_tb;

  // About 30 key runs are made, each well under 40 cycles
  localparam int RUN_LIMIT  = 50;
  localparam int RUN_CYCLES = 40;
  localparam int MAX_CYCLES = RUN_LIMIT * RUN_CYCLES;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         start_i;
  aes_ks_types_pkg::full_key_t  key_i;
  aes_ks_types_pkg::key_len_e   key_len_i;
  aes_ks_types_pkg::round_t     rd_round_i;
  logic                         busy_o;
  logic                         done_o;
  aes_ks_types_pkg::round_key_t rd_key_o;

  integer                       seed;
  int                           cycles = 0;
  int                           errors = 0;
  int                           checks = 0;
  int                           test_num = 0;
  int                           test_err_base = 0;
  logic                         rd_req;
  aes_ks_types_pkg::round_key_t rd_exp;
  logic                         chk_valid = 1'b0;
  aes_ks_types_pkg::round_key_t chk_exp;
  aes_ks_types_pkg::round_t     chk_round;

  aes_key_sched_top dut0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_i),
    .key_i      (key_i),
    .key_len_i  (key_len_i),
    .rd_round_i (rd_round_i),
    .busy_o     (busy_o),
    .done_o     (done_o),
    .rd_key_o   (rd_key_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // FIPS-197 KeyExpansion, returns words 4r to 4r+3
  function automatic aes_ks_types_pkg::round_key_t ref_expand(
    input aes_ks_types_pkg::full_key_t key,
    input aes_ks_types_pkg::key_len_e  len,
    input int                          r
  );
    aes_ks_types_pkg::word_t w [64];
    aes_ks_types_pkg::word_t temp;
    logic [7:0]              rcon;
    int                      nk;
    int                      i;
    nk   = (len == aes_ks_types_pkg::AES_256) ? 8 :
           (len == aes_ks_types_pkg::AES_192) ? 6 : 4;
    rcon = 8'h01;
    for (i = 0; i < nk; i++) begin
      w[i] = key[i];
    end
    // Nb * (Nr + 1) words with Nr = Nk + 6
    for (i = nk; i < 4 * (nk + 7); i++) begin
      temp = w[i-1];
      if (i % nk == 0) begin
        temp = aes_ks_math_pkg::sub_word(aes_ks_math_pkg::rot_word(temp)) ^ {rcon, 24'h0};
        rcon = aes_ks_math_pkg::gf_mul2(rcon);
      end else if (nk > 6 && i % nk == 4) begin
        temp = aes_ks_math_pkg::sub_word(temp);
      end
      w[i] = w[i-nk] ^ temp;
    end
    return {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
  endfunction

  function automatic int key_count(input aes_ks_types_pkg::key_len_e len);
    return (len == aes_ks_types_pkg::AES_256) ? 15 :
           (len == aes_ks_types_pkg::AES_192) ? 13 : 11;
  endfunction

  // Words strobes per run
  function automatic int strobe_count(input aes_ks_types_pkg::key_len_e len);
    return (len == aes_ks_types_pkg::AES_256) ? 14 :
           (len == aes_ks_types_pkg::AES_192) ? 13 : 11;
  endfunction

  function automatic aes_ks_types_pkg::full_key_t fips_key(
    input aes_ks_types_pkg::key_len_e len
  );
    aes_ks_types_pkg::full_key_t k;
    k = '0;
    if (len == aes_ks_types_pkg::AES_128) begin
      k[3:0] = {32'h09cf4f3c, 32'habf71588, 32'h28aed2a6, 32'h2b7e1516};
    end else if (len == aes_ks_types_pkg::AES_192) begin
      k[5:0] = {32'h522c6b7b, 32'h62f8ead2, 32'h809079e5,
                32'hc810f32b, 32'hda0e6452, 32'h8e73b0f7};
    end else begin
      k = {32'h0914dff4, 32'h2d9810a3, 32'h3b6108d7, 32'h1f352c07,
           32'h857d7781, 32'h2b73aef0, 32'h15ca71be, 32'h603deb10};
    end
    return k;
  endfunction

  // Upper words stay random, the DUT must ignore them
  function automatic aes_ks_types_pkg::full_key_t random_key();
    aes_ks_types_pkg::full_key_t k;
    for (int i = 0; i < 8; i++) begin
      k[i] = $random(seed);
    end
    return k;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Read-back comparison
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    chk_valid <= rd_req;
    chk_exp   <= rd_exp;
    chk_round <= rd_round_i;
  end

  always @(negedge clk_i) begin
    if (chk_valid) begin
      checks = checks + 1;
      if (rd_key_o !== chk_exp) begin
        errors = errors + 1;
        $display("[FAIL] %0t: round %0d key %h, expected %h",
                 $time, chk_round, rd_key_o, chk_exp);
      end
    end
  end

  task automatic launch(
    input  aes_ks_types_pkg::full_key_t key,
    input  aes_ks_types_pkg::key_len_e  len,
    output int                          t0
  );
    @(negedge clk_i);
    t0        = cycles;
    start_i   = 1'b1;
    key_i     = key;
    key_len_i = len;
    @(negedge clk_i);
    start_i = 1'b0;
    key_i   = '0;
    if (!busy_o || done_o) begin
      errors = errors + 1;
      $display("[FAIL] %0t: busy_o not high or done_o not low after start", $time);
    end
  endtask

  task automatic wait_done(input aes_ks_types_pkg::key_len_e len, input int t0);
    while (!done_o) begin
      @(negedge clk_i);
    end
    if (cycles - t0 != strobe_count(len) + 1) begin
      errors = errors + 1;
      $display("[FAIL] %0t: done_o rose %0d cycles after start, expected %0d",
               $time, cycles - t0, strobe_count(len) + 1);
    end
  endtask

  task automatic read_one(
    input aes_ks_types_pkg::full_key_t key,
    input aes_ks_types_pkg::key_len_e  len,
    input int                          r
  );
    @(negedge clk_i);
    if (!done_o) begin
      errors = errors + 1;
      $display("[FAIL] %0t: done_o low while round keys are read", $time);
    end
    rd_round_i = aes_ks_types_pkg::round_t'(r);
    rd_req     = 1'b1;
    rd_exp     = ref_expand(key, len, r);
  endtask

  // Lets the last read reach the compare process
  task automatic drain_reads();
    @(negedge clk_i);
    rd_req = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic read_all(
    input aes_ks_types_pkg::full_key_t key,
    input aes_ks_types_pkg::key_len_e  len
  );
    for (int r = 0; r < key_count(len); r++) begin
      read_one(key, len, r);
    end
    drain_reads();
  endtask

  task automatic run_key(
    input aes_ks_types_pkg::full_key_t key,
    input aes_ks_types_pkg::key_len_e  len
  );
    int t0;
    launch(key, len, t0);
    wait_done(len, t0);
    read_all(key, len);
  endtask

  // Anchors the reference on the last round key printed in FIPS-197
  task automatic run_fips(
    input aes_ks_types_pkg::key_len_e   len,
    input aes_ks_types_pkg::round_key_t last_key
  );
    aes_ks_types_pkg::round_key_t ref_last;
    ref_last = ref_expand(fips_key(len), len, key_count(len) - 1);
    if (ref_last !== last_key) begin
      errors = errors + 1;
      $display("[FAIL] %0t: reference last round key %h, FIPS-197 gives %h",
               $time, ref_last, last_key);
    end
    run_key(fips_key(len), len);
  endtask

  task automatic report_test(input string name);
    test_num = test_num + 1;
    $display("test %0d %s: %s", test_num, name,
             (errors == test_err_base) ? "ok" : "failed");
    test_err_base = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    aes_ks_types_pkg::full_key_t key_a;
    aes_ks_types_pkg::full_key_t key_b;
    aes_ks_types_pkg::key_len_e  len;
    int                          t0;
    int                          t1;
    int                          r;
    seed       = 32'h34b2;
    rst_ni     = 1'b0;
    start_i    = 1'b0;
    key_i      = '0;
    key_len_i  = aes_ks_types_pkg::AES_128;
    rd_round_i = '0;
    rd_req     = 1'b0;
    rd_exp     = '0;

    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    if (busy_o || done_o || rd_key_o !== '0) begin
      errors = errors + 1;
      $display("[FAIL] %0t: outputs not at their reset values", $time);
    end
    report_test("reset values");

    run_fips(aes_ks_types_pkg::AES_128, 128'hd014f9a8_c9ee2589_e13f0cc8_b6630ca6);
    report_test("FIPS-197 AES-128 key");
    run_fips(aes_ks_types_pkg::AES_192, 128'he98ba06f_448c773c_8ecc7204_01002202);
    run_fips(aes_ks_types_pkg::AES_256, 128'hfe4890d1_e6188d0b_046df344_706c631e);
    report_test("FIPS-197 AES-192 and AES-256 keys");

    for (int n = 0; n < 24; n++) begin
      len = aes_ks_types_pkg::key_len_e'(n % 3);
      run_key(random_key(), len);
    end
    report_test("random keys, lengths interleaved");

    // Second start lands while busy and must be dropped
    key_a = random_key();
    key_b = random_key();
    launch(key_a, aes_ks_types_pkg::AES_128, t0);
    launch(key_b, aes_ks_types_pkg::AES_256, t1);
    wait_done(aes_ks_types_pkg::AES_128, t0);
    read_all(key_a, aes_ks_types_pkg::AES_128);
    report_test("start while busy ignored");

    key_a = random_key();
    run_key(key_a, aes_ks_types_pkg::AES_256);
    for (int n = 0; n < 12; n++) begin
      r = $unsigned($random(seed)) % (`AES_KS_MAX_ROUNDS + 1);
      read_one(key_a, aes_ks_types_pkg::AES_256, r);
      read_one(key_a, aes_ks_types_pkg::AES_256, r);
    end
    drain_reads();
    report_test("random order reads");

    $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- dv/aes_key_sched_sva.sv
/*
  AES key schedule protocol assertions
  Words strobe, strobe size and busy/done relation
*/
`timescale 1ns/100ps

module aes_key_sched_sva (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        words_valid_i,
  input aes_ks_types_pkg::word_cnt_t word_cnt_i,
  input logic                        busy_i,
  input logic                        done_i
);

  // Strobes only come from a running controller
  valid_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    words_valid_i |-> busy_i)
    else $error("words strobe while the controller is idle");

  cnt_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    words_valid_i |-> (word_cnt_i inside {4'd2, 4'd4, 4'd6, 4'd8}))
    else $error("words strobe with word count %0d", word_cnt_i);

  busy_done_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(busy_i && done_i))
    else $error("busy and done high together");

endmodule

// Bound at the top, where controller strobes and bank done meet
bind aes_key_sched_top aes_key_sched_sva sva0 (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .words_valid_i (words_valid),
  .word_cnt_i    (word_cnt),
  .busy_i        (busy),
  .done_i        (done_o)
);

//--- verilog/aes_key_sched_top.sv
/*
  AES key schedule unit
  Controller and expansion step produce the word schedule,
  the round-key bank stores it and serves round keys
*/
`timescale 1ns/100ps

module aes_key_sched_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         start_i,
  input  aes_ks_types_pkg::full_key_t  key_i,
  input  aes_ks_types_pkg::key_len_e   key_len_i,
  input  aes_ks_types_pkg::round_t     rd_round_i,
  output logic                         busy_o,
  output logic                         done_o,
  output aes_ks_types_pkg::round_key_t rd_key_o
);

  logic                        clear;
  logic                        advance;
  aes_ks_types_pkg::round_t    round;
  aes_ks_types_pkg::key_len_e  key_len;
  aes_ks_types_pkg::full_key_t cur_key;
  aes_ks_types_pkg::full_key_t next_key;
  aes_ks_types_pkg::word_cnt_t new_cnt;
  logic                        words_valid;
  logic                        first_strobe;
  aes_ks_types_pkg::full_key_t words;
  aes_ks_types_pkg::word_cnt_t word_cnt;
  logic                        busy;

  aes_key_sched_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .key_i          (key_i),
    .key_len_i      (key_len_i),
    .next_key_i     (next_key),
    .new_cnt_i      (new_cnt),
    .clear_o        (clear),
    .advance_o      (advance),
    .round_o        (round),
    .key_len_o      (key_len),
    .cur_key_o      (cur_key),
    .words_valid_o  (words_valid),
    .first_strobe_o (first_strobe),
    .words_o        (words),
    .word_cnt_o     (word_cnt),
    .busy_o         (busy)
  );

  aes_key_expand u_expand (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clear_i   (clear),
    .advance_i (advance),
    .round_i   (round),
    .key_len_i (key_len),
    .key_i     (cur_key),
    .key_o     (next_key),
    .new_cnt_o (new_cnt)
  );

  aes_round_key_bank u_bank (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .words_valid_i  (words_valid),
    .first_strobe_i (first_strobe),
    .words_i        (words),
    .word_cnt_i     (word_cnt),
    .busy_i         (busy),
    .rd_round_i     (rd_round_i),
    .rd_key_o       (rd_key_o),
    .done_o         (done_o)
  );

  assign busy_o = busy;

endmodule

//--- verilog/aes_round_key_bank.sv
/*
  AES round-key bank
  Stores the schedule words as they arrive and returns one
  128-bit round key per read, one cycle after the request
*/
`timescale 1ns/100ps
`include "aes_ks_settings.svh"

module aes_round_key_bank (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         words_valid_i,
  input  logic                         first_strobe_i,
  input  aes_ks_types_pkg::full_key_t  words_i,
  input  aes_ks_types_pkg::word_cnt_t  word_cnt_i,
  input  logic                         busy_i,
  input  aes_ks_types_pkg::round_t     rd_round_i,
  output aes_ks_types_pkg::round_key_t rd_key_o,
  output logic                         done_o
);

  aes_ks_types_pkg::word_t     mem [`AES_KS_MAX_WORDS];
  aes_ks_types_pkg::word_idx_t wr_ptr_q;
  aes_ks_types_pkg::word_idx_t wr_base;
  aes_ks_types_pkg::word_idx_t rd_base;
  logic                        busy_q;
  logic                        done_q;
  logic                        busy_fall;

  // A new schedule restarts at word 0
  assign wr_base = first_strobe_i ? '0 : wr_ptr_q;

  always_ff @(posedge clk_i) begin : word_store
    if (words_valid_i) begin
      for (int i = 0; i < 8; i++) begin
        if (i < int'(word_cnt_i)) begin
          mem[int'(wr_base) + i] <= words_i[i];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : wr_pointer
    if (!rst_ni) begin
      wr_ptr_q <= '0;
    end else if (words_valid_i) begin
      wr_ptr_q <= wr_base + aes_ks_types_pkg::word_idx_t'(word_cnt_i);
    end
  end

  // Done follows the falling edge of busy, cleared by the next run
  assign busy_fall = busy_q & ~busy_i;
  assign done_o    = busy_fall | (done_q & ~first_strobe_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin : done_flag
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      busy_q <= busy_i;
      done_q <= done_o;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////

  assign rd_base = {rd_round_i, 2'b00};

  always_ff @(posedge clk_i or negedge rst_ni) begin : read_port
    if (!rst_ni) begin
      rd_key_o <= '0;
    end else if (rd_round_i <= `AES_KS_MAX_ROUNDS) begin
      rd_key_o <= {mem[rd_base], mem[rd_base + 6'd1],
                   mem[rd_base + 6'd2], mem[rd_base + 6'd3]};
    end else begin
      rd_key_o <= '0;
    end
  end

endmodule

//--- verilog/aes_key_sched_ctrl.sv
/*
  AES key schedule controller
  Loads the cipher key, steps the rounds one per cycle and
  strobes the new schedule words towards the round-key bank
*/
`timescale 1ns/100ps
`include "aes_ks_settings.svh"

module aes_key_sched_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         start_i,
  input  aes_ks_types_pkg::full_key_t  key_i,
  input  aes_ks_types_pkg::key_len_e   key_len_i,
  input  aes_ks_types_pkg::full_key_t  next_key_i,
  input  aes_ks_types_pkg::word_cnt_t  new_cnt_i,
  output logic                         clear_o,
  output logic                         advance_o,
  output aes_ks_types_pkg::round_t     round_o,
  output aes_ks_types_pkg::key_len_e   key_len_o,
  output aes_ks_types_pkg::full_key_t  cur_key_o,
  output logic                         words_valid_o,
  output logic                         first_strobe_o,
  output aes_ks_types_pkg::full_key_t  words_o,
  output aes_ks_types_pkg::word_cnt_t  word_cnt_o,
  output logic                         busy_o
);

  typedef enum logic [1:0] {IDLE, LOAD, STEP} ks_state_e;

  ks_state_e                   state_q, state_d;
  aes_ks_types_pkg::key_len_e  key_len_q;
  aes_ks_types_pkg::round_t    round_q;
  aes_ks_types_pkg::round_t    round_end;
  aes_ks_types_pkg::full_key_t cur_key_q;
  aes_ks_types_pkg::full_key_t words_q;
  aes_ks_types_pkg::full_key_t new_words;
  aes_ks_types_pkg::word_cnt_t cnt_q;
  aes_ks_types_pkg::word_cnt_t src_base;
  logic                        valid_q;
  logic                        first_q;
  logic                        accept;
  logic                        step_en;

  // Nk, the key length in words
  function automatic aes_ks_types_pkg::word_cnt_t nk_words(
    input aes_ks_types_pkg::key_len_e len
  );
    unique case (len)
      aes_ks_types_pkg::AES_192: return 4'd6;
      aes_ks_types_pkg::AES_256: return 4'd8;
      default:                   return 4'd4;
    endcase
  endfunction

  assign accept = (state_q == IDLE) && start_i;

  // One past the last round that is stepped
  always_comb begin : round_limit
    unique case (key_len_q)
      aes_ks_types_pkg::AES_192: round_end = 4'd12;
      aes_ks_types_pkg::AES_256: round_end = aes_ks_types_pkg::round_t'(`AES_KS_MAX_ROUNDS);
      default:                   round_end = 4'd10;
    endcase
  end

  assign step_en = (state_q != IDLE) && (round_q != round_end);

  always_comb begin : next_state
    unique case (state_q)
      IDLE:    state_d = accept ? LOAD : IDLE;
      LOAD:    state_d = STEP;
      STEP:    state_d = step_en ? STEP : IDLE;
      default: state_d = IDLE;
    endcase
  end

  // New words sit at the top of the Nk live words, move them down to word 0
  assign src_base = nk_words(key_len_q) - new_cnt_i;

  always_comb begin : compact_words
    for (int i = 0; i < 8; i++) begin
      if (int'(src_base) + i < 8) begin
        new_words[i] = next_key_i[int'(src_base) + i];
      end else begin
        new_words[i] = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      state_q   <= IDLE;
      key_len_q <= aes_ks_types_pkg::AES_128;
      round_q   <= '0;
      cnt_q     <= '0;
      valid_q   <= 1'b0;
      first_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= accept | step_en;
      first_q <= accept;
      if (accept) begin
        key_len_q <= key_len_i;
        // AES-256 round 0 adds nothing beyond the key itself
        round_q   <= (key_len_i == aes_ks_types_pkg::AES_256) ? 4'd1 : 4'd0;
        cnt_q     <= nk_words(key_len_i);
      end else if (step_en) begin
        round_q <= round_q + 4'd1;
        cnt_q   <= new_cnt_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin : key_regs
    if (accept) begin
      cur_key_q <= key_i;
      words_q   <= key_i;
    end else if (step_en) begin
      cur_key_q <= next_key_i;
      words_q   <= new_words;
    end
  end

  assign clear_o        = accept;
  assign advance_o      = step_en;
  assign round_o        = round_q;
  assign key_len_o      = key_len_q;
  assign cur_key_o      = cur_key_q;
  assign words_valid_o  = valid_q;
  assign first_strobe_o = first_q;
  assign words_o        = words_q;
  assign word_cnt_o     = cnt_q;
  assign busy_o         = (state_q != IDLE);

endmodule

//--- verilog/aes_key_expand.sv
/*
  AES forward key expansion step
  Computes one round of the key schedule from the working key
  register and keeps the Rcon register
*/
`timescale 1ns/100ps

module aes_key_expand (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         advance_i,
  input  aes_ks_types_pkg::round_t     round_i,
  input  aes_ks_types_pkg::key_len_e   key_len_i,
  input  aes_ks_types_pkg::full_key_t  key_i,
  output aes_ks_types_pkg::full_key_t  key_o,
  output aes_ks_types_pkg::word_cnt_t  new_cnt_o
);

  logic [7:0]                  rcon_q;
  logic [7:0]                  rcon_d;
  logic                        rcon_we;
  logic                        use_rcon;
  logic                        use_rot_word;
  aes_ks_types_pkg::round_t    rnd_mod3;
  logic                        r192_first;
  logic                        r192_plain;
  logic                        r192_sub_lo;
  logic                        r192_sub_hi;
  aes_ks_types_pkg::word_t     spec_192;
  aes_ks_types_pkg::word_t     rot_in;
  aes_ks_types_pkg::word_t     sub_in;
  aes_ks_types_pkg::word_t     sub_out;
  aes_ks_types_pkg::word_t     irregular;
  aes_ks_types_pkg::full_key_t next_key;

  // AES-192 repeats a pattern of three rounds after round 0
  assign rnd_mod3    = round_i % 4'd3;
  assign r192_first  = (round_i == '0);
  assign r192_plain  = !r192_first && (rnd_mod3 == 4'd1);
  assign r192_sub_lo = !r192_first && (rnd_mod3 == 4'd2);
  assign r192_sub_hi = !r192_first && (rnd_mod3 == 4'd0);

  //////////////////////////////////////////////////////////////////////
  // RotWord, SubWord and Rcon
  //////////////////////////////////////////////////////////////////////

  // AES-256 even rounds take SubWord alone
  assign use_rot_word = !(key_len_i == aes_ks_types_pkg::AES_256 && !round_i[0]);
  assign use_rcon     = !((key_len_i == aes_ks_types_pkg::AES_192 && r192_plain) ||
                          (key_len_i == aes_ks_types_pkg::AES_256 && !round_i[0]));

  // Equals the word produced just before the SubWord slot on a type 3 round
  assign spec_192 = key_i[5] ^ key_i[1] ^ key_i[0];

  always_comb begin : rot_in_mux
    unique case (key_len_i)
      aes_ks_types_pkg::AES_192: begin
        if (r192_sub_hi) begin
          rot_in = spec_192;
        end else if (r192_plain) begin
          rot_in = key_i[3];
        end else begin
          rot_in = key_i[5];
        end
      end
      aes_ks_types_pkg::AES_256: rot_in = key_i[7];
      default:                   rot_in = key_i[3];
    endcase
  end

  assign sub_in    = use_rot_word ? aes_ks_math_pkg::rot_word(rot_in) : rot_in;
  assign sub_out   = aes_ks_math_pkg::sub_word(sub_in);
  // Rcon lands on byte a0
  assign irregular = use_rcon ? (sub_out ^ {rcon_q, 24'h000000}) : sub_out;

  assign rcon_d  = clear_i ? 8'h01 : aes_ks_math_pkg::gf_mul2(rcon_q);
  assign rcon_we = clear_i | (advance_i & use_rcon);

  always_ff @(posedge clk_i or negedge rst_ni) begin : rcon_reg
    if (!rst_ni) begin
      rcon_q <= 8'h00;
    end else if (rcon_we) begin
      rcon_q <= rcon_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next key register
  //////////////////////////////////////////////////////////////////////

  always_comb begin : next_key_mux
    next_key = key_i;
    unique case (key_len_i)
      aes_ks_types_pkg::AES_128: begin
        next_key[0] = irregular ^ key_i[0];
        for (int i = 1; i < 4; i++) begin
          next_key[i] = next_key[i-1] ^ key_i[i];
        end
      end
      aes_ks_types_pkg::AES_192: begin
        if (r192_first) begin
          // Six key words become w2..w7
          next_key[3:0] = key_i[5:2];
          next_key[4]   = irregular ^ key_i[0];
          next_key[5]   = next_key[4] ^ key_i[1];
        end else begin
          next_key[1:0] = key_i[5:4];
          for (int i = 0; i < 4; i++) begin
            if ((i == 0 && r192_sub_lo) || (i == 2 && r192_sub_hi)) begin
              next_key[i+2] = irregular ^ key_i[i];
            end else begin
              next_key[i+2] = next_key[i+1] ^ key_i[i];
            end
          end
        end
      end
      aes_ks_types_pkg::AES_256: begin
        // Round 0 leaves the register as loaded
        if (round_i != '0) begin
          next_key[3:0] = key_i[7:4];
          next_key[4]   = irregular ^ key_i[0];
          for (int i = 5; i < 8; i++) begin
            next_key[i] = next_key[i-1] ^ key_i[i-4];
          end
        end
      end
      default: next_key = key_i;
    endcase
  end

  always_comb begin : new_cnt_mux
    unique case (key_len_i)
      aes_ks_types_pkg::AES_192: new_cnt_o = r192_first ? 4'd2 : 4'd4;
      aes_ks_types_pkg::AES_256: new_cnt_o = (round_i == '0) ? 4'd0 : 4'd4;
      default:                   new_cnt_o = 4'd4;
    endcase
  end

  assign key_o = next_key;

endmodule

//--- verilog/aes_ks_math_pkg.sv
/*
  AES field arithmetic
  Forward S-Box table, GF(2^8) doubling and the word operations
  of the key schedule
*/
package aes_ks_math_pkg;

  // Forward S-Box, indexed by input byte
  parameter logic [7:0] sbox_table [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] gf_mul2(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // [a0 a1 a2 a3] -> [a1 a2 a3 a0]
  function automatic aes_ks_types_pkg::word_t rot_word(input aes_ks_types_pkg::word_t w);
    return {w[23:0], w[31:24]};
  endfunction

  function automatic aes_ks_types_pkg::word_t sub_word(input aes_ks_types_pkg::word_t w);
    return {sbox_table[w[31:24]], sbox_table[w[23:16]],
            sbox_table[w[15:8]], sbox_table[w[7:0]]};
  endfunction

endpackage

//--- verilog/aes_ks_types_pkg.sv
/*
  AES key schedule data types
  Words, key registers, indices and the key length encoding
*/
package aes_ks_types_pkg;

  // One schedule word, byte a0 of FIPS-197 in bits [31:24]
  typedef logic [31:0] word_t;

  // Working key register, word 0 is the first key word
  typedef word_t [7:0] full_key_t;

  typedef enum logic [1:0] {
    AES_128 = 2'b00,
    AES_192 = 2'b01,
    AES_256 = 2'b10
  } key_len_e;

  // Round index, 0 to 14
  typedef logic [3:0] round_t;

  // Word position in the schedule, 0 to 59
  typedef logic [5:0] word_idx_t;

  // New words in one strobe, 0 to 8
  typedef logic [3:0] word_cnt_t;

  // Round key r, word 4r in bits [127:96]
  typedef logic [127:0] round_key_t;

endpackage

//--- verilog/aes_ks_settings.svh
/*
  AES key schedule sizing
  Upper bounds of the forward word schedule, shared by the
  controller, the round-key bank and the testbench
*/
`ifndef AES_KS_SETTINGS_SVH
`define AES_KS_SETTINGS_SVH

// Words in the longest schedule (AES-256, Nb * (Nr + 1))
`define AES_KS_MAX_WORDS 60

// Highest round index (AES-256)
`define AES_KS_MAX_ROUNDS 14

`endif
